//--- Bender.yml
package:
  name: raster_block_stage

sources:
  - logic/raster_pkg.sv
  - logic/raster_fifo.sv
  - logic/raster_quad_eval.sv
  - logic/raster_block_eval.sv
  - logic/raster_quad_out.sv
  - logic/raster_top.sv
  - target: test
    files:
      - test/raster_properties.sv
      - test/raster_tb.sv

//--- all.f
logic/raster_pkg.sv
logic/raster_fifo.sv
logic/raster_quad_eval.sv
logic/raster_block_eval.sv
logic/raster_quad_out.sv
logic/raster_top.sv
test/raster_properties.sv
test/raster_tb.sv

//--- logic/raster_block_eval.sv
`timescale 1ns/1ps
// Block evaluator
// Splits a block into 2x2 quads, evaluates them all in parallel,
// holds the results and hands covered quads to the lanes a slice at a time

module raster_block_eval import raster_pkg::*; #(
    parameter int block_size = default_block_size,
    parameter int quad_rate  = default_quad_rate
) (
    input  logic                         clk,
    input  logic                         reset,
    input  raster_block_t                block,
    input  logic                         block_avail,
    input  logic [quad_rate-1:0]         lane_full,
    output logic                         block_take,
    output logic [quad_rate-1:0]         lane_push,
    output raster_quad_t [quad_rate-1:0] lane_quad
);

    localparam int quad_side   = block_size / 2;
    localparam int quad_count  = quad_side * quad_side;
    localparam int slice_count = quad_count / quad_rate;
    localparam int slice_bits  = (slice_count > 1) ? $clog2(slice_count) : 1;

    // Quad results from the head block, pixel coordinates
    raster_quad_t [quad_count-1:0] quad_d;
    // Quad results held for the slice walk
    raster_quad_t [quad_count-1:0] quad_q;

    logic                  busy;
    logic [slice_bits-1:0] slice;
    logic                  stall;
    logic                  advance;
    logic                  last_slice;

    for (genvar q = 0; q < quad_count; q++) begin : g_quad
        // Quad column and row inside the block
        localparam int qi = q / quad_side;
        localparam int qj = q % quad_side;

        raster_data_t [2:0]      origin_val;
        logic [3:0]              eval_mask;
        raster_data_t [2:0][3:0] eval_bcoords;

        // Shift edge values from block origin to quad origin
        always_comb begin
            for (int k = 0; k < 3; k++) begin
                origin_val[k] = block.edge_func_val[k]
                    + raster_data_t'(2 * qi) * block.edges[k].a
                    + raster_data_t'(2 * qj) * block.edges[k].b;
            end
        end

        raster_quad_eval u_quad_eval (
            .edges         (block.edges),
            .edge_func_val (origin_val),
            .mask          (eval_mask),
            .bcoords       (eval_bcoords)
        );

        assign quad_d[q] = '{
            x_loc:   block.x_loc + raster_dim_t'(2 * qi),
            y_loc:   block.y_loc + raster_dim_t'(2 * qj),
            pid:     block.pid,
            mask:    eval_mask,
            bcoords: eval_bcoords
        };
    end

    // Any full lane holds the whole slice
    assign stall      = |lane_full;
    assign advance    = busy && !stall;
    assign last_slice = (slice == slice_bits'(slice_count - 1));

    // Next block may be taken in the cycle the last slice goes out
    assign block_take = block_avail && (!busy || (advance && last_slice));

    always_ff @(posedge clk) begin
        if (block_take) begin
            quad_q <= quad_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            slice <= '0;
        end else if (block_take) begin
            busy  <= 1'b1;
            slice <= '0;
        end else if (advance) begin
            if (last_slice) begin
                busy <= 1'b0;
            end else begin
                slice <= slice + 1'b1;
            end
        end
    end

    // Lane l takes quad slice*quad_rate + l, empty quads are skipped
    always_comb begin
        raster_quad_t sel;
        for (int l = 0; l < quad_rate; l++) begin
            sel                = quad_q[int'(slice) * quad_rate + l];
            lane_quad[l]       = sel;
            lane_quad[l].x_loc = sel.x_loc >> 1;
            lane_quad[l].y_loc = sel.y_loc >> 1;
            lane_push[l]       = advance && (sel.mask != 4'b0000);
        end
    end

endmodule

//--- logic/raster_fifo.sv
`timescale 1ns/1ps
// Synchronous FIFO with a generic payload type
// Circular buffer with occupancy count and full/empty flags

module raster_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     full,
    output logic     empty
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

    payload_t            mem [depth];
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits:0]   count;
    logic                do_push;
    logic                do_pop;

    // Refuse push when full and pop when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == depth[ptr_bits:0]);
    assign empty    = (count == '0);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/raster_pkg.sv
// Shared rasterizer definitions
// Field widths, edge/block/quad payload structs and the
// default block stage parameters

package raster_pkg;

    // Field widths
    localparam int dim_bits  = 16;
    localparam int data_bits = 32;

    typedef logic [dim_bits-1:0]         raster_dim_t;
    typedef logic signed [data_bits-1:0] raster_data_t;

    // One edge equation a*x + b*y + c
    typedef struct packed {
        raster_data_t a;
        raster_data_t b;
        raster_data_t c;
    } raster_edge_t;

    // One 4x4 screen block of a primitive
    typedef struct packed {
        raster_dim_t             x_loc;
        raster_dim_t             y_loc;
        raster_data_t            pid;
        raster_edge_t [2:0]      edges;
        // Edge function values at the block origin pixel
        raster_data_t [2:0]      edge_func_val;
    } raster_block_t;

    // One covered 2x2 quad, coordinates in quad units
    typedef struct packed {
        raster_dim_t             x_loc;
        raster_dim_t             y_loc;
        raster_data_t            pid;
        // Bit order (0,0) (1,0) (0,1) (1,1)
        logic [3:0]              mask;
        // Edge index first, then pixel in mask order
        raster_data_t [2:0][3:0] bcoords;
    } raster_quad_t;

    // Defaults passed down from the top level
    localparam int default_block_size  = 4;
    localparam int default_quad_rate   = 2;
    localparam int default_quad_depth  = 16;
    localparam int default_block_depth = 2;

endpackage

//--- logic/raster_quad_eval.sv
`timescale 1ns/1ps
// Quad evaluator
// Edge values and coverage mask for the four pixels of one 2x2 quad

module raster_quad_eval import raster_pkg::*; (
    input  raster_edge_t [2:0]      edges,
    // Edge values at the quad origin pixel
    input  raster_data_t [2:0]      edge_func_val,
    output logic [3:0]              mask,
    output raster_data_t [2:0][3:0] bcoords
);

    always_comb begin
        mask = 4'b1111;
        for (int p = 0; p < 4; p++) begin
            for (int k = 0; k < 3; k++) begin
                // Step right adds a, step down adds b
                bcoords[k][p] = edge_func_val[k]
                    + (p[0] ? edges[k].a : raster_data_t'(0))
                    + (p[1] ? edges[k].b : raster_data_t'(0));
                // Pixel is outside when any edge value is negative
                if (bcoords[k][p][data_bits-1]) begin
                    mask[p] = 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/raster_quad_out.sv
`timescale 1ns/1ps
// Quad output stage
// One quad FIFO per lane, shared pop and the valid/empty summary

module raster_quad_out import raster_pkg::*; #(
    parameter int quad_rate  = default_quad_rate,
    parameter int quad_depth = default_quad_depth
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [quad_rate-1:0]         lane_push,
    input  raster_quad_t [quad_rate-1:0] lane_quad,
    input  logic                         quad_pop,
    output logic [quad_rate-1:0]         lane_full,
    output raster_quad_t [quad_rate-1:0] quads,
    output logic [quad_rate-1:0]         quad_valid,
    output logic                         quad_empty
);

    logic [quad_rate-1:0] lane_empty;
    logic [quad_rate-1:0] lane_pop;

    for (genvar l = 0; l < quad_rate; l++) begin : g_lane
        // Only lanes with data see the pop
        assign lane_pop[l] = quad_pop && !lane_empty[l];

        raster_fifo #(
            .payload_t (raster_quad_t),
            .depth     (quad_depth)
        ) u_quad_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (lane_push[l]),
            .pop      (lane_pop[l]),
            .data_in  (lane_quad[l]),
            .data_out (quads[l]),
            .full     (lane_full[l]),
            .empty    (lane_empty[l])
        );
    end

    assign quad_valid = ~lane_empty;
    assign quad_empty = &lane_empty;

endmodule

//--- logic/raster_top.sv
`timescale 1ns/1ps
// Rasterizer block stage top level
// Block queue, block evaluator and per-lane quad output

module raster_top import raster_pkg::*; #(
    parameter int block_size  = default_block_size,
    parameter int quad_rate   = default_quad_rate,
    parameter int quad_depth  = default_quad_depth,
    parameter int block_depth = default_block_depth
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         block_valid,
    input  raster_block_t                block,
    input  logic                         quad_pop,
    output logic                         block_ready,
    output raster_quad_t [quad_rate-1:0] quads,
    output logic [quad_rate-1:0]         quad_valid,
    output logic                         quad_empty
);

    raster_block_t                head_block;
    logic                         block_full;
    logic                         block_empty;
    logic                         block_take;
    logic [quad_rate-1:0]         lane_push;
    logic [quad_rate-1:0]         lane_full;
    raster_quad_t [quad_rate-1:0] lane_quad;

    assign block_ready = !block_full;

    // Incoming whole blocks
    raster_fifo #(
        .payload_t (raster_block_t),
        .depth     (block_depth)
    ) u_block_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (block_valid),
        .pop      (block_take),
        .data_in  (block),
        .data_out (head_block),
        .full     (block_full),
        .empty    (block_empty)
    );

    raster_block_eval #(
        .block_size (block_size),
        .quad_rate  (quad_rate)
    ) u_block_eval (
        .clk         (clk),
        .reset       (reset),
        .block       (head_block),
        .block_avail (!block_empty),
        .lane_full   (lane_full),
        .block_take  (block_take),
        .lane_push   (lane_push),
        .lane_quad   (lane_quad)
    );

    raster_quad_out #(
        .quad_rate  (quad_rate),
        .quad_depth (quad_depth)
    ) u_quad_out (
        .clk        (clk),
        .reset      (reset),
        .lane_push  (lane_push),
        .lane_quad  (lane_quad),
        .quad_pop   (quad_pop),
        .lane_full  (lane_full),
        .quads      (quads),
        .quad_valid (quad_valid),
        .quad_empty (quad_empty)
    );

endmodule

//--- test/raster_properties.sv
`timescale 1ns/1ps
// Concurrent checks on the block stage handshakes, bound to raster_top

module raster_properties import raster_pkg::*; #(
    parameter int quad_rate = default_quad_rate
) (
    input logic                         clk,
    input logic                         reset,
    input logic                         block_valid,
    input logic                         block_ready,
    input raster_block_t                block,
    input logic                         quad_pop,
    input logic [quad_rate-1:0]         quad_valid,
    input logic                         quad_empty
);

    assert property (@(posedge clk) disable iff (reset) quad_empty |-> quad_valid == '0)
    else $error("quad_valid is set while quad_empty is high");

    assert property (@(posedge clk) $fell(reset) |-> quad_empty && block_ready)
    else $error("outputs not idle in the cycle after reset");

    // Source holds the block while it waits
    assert property (@(posedge clk) disable iff (reset)
        block_valid && !block_ready |=> $stable(block))
    else $error("block changed while waiting for block_ready");

    assert property (@(posedge clk) disable iff (reset)
        !quad_pop |=> ($past(quad_valid) & ~quad_valid) == '0)
    else $error("quad_valid fell on a lane without quad_pop");

endmodule

bind raster_top raster_properties #(.quad_rate(quad_rate)) u_properties (
    .clk         (clk),
    .reset       (reset),
    .block_valid (block_valid),
    .block_ready (block_ready),
    .block       (block),
    .quad_pop    (quad_pop),
    .quad_valid  (quad_valid),
    .quad_empty  (quad_empty)
);

//--- test/raster_tb.sv
`timescale 1ns/1ps
// Directed testbench for the rasterizer block stage
// Reference model with per-lane expected queues, block send,
// pop/check and drain tasks, six directed tests

module raster_tb import raster_pkg::*; ();

    localparam int quad_rate = default_quad_rate;
    localparam int quad_side = default_block_size / 2;

    logic                         clk;
    logic                         reset;
    logic                         block_valid;
    raster_block_t                block;
    logic                         quad_pop;
    logic                         block_ready;
    raster_quad_t [quad_rate-1:0] quads;
    logic [quad_rate-1:0]         quad_valid;
    logic                         quad_empty;

    raster_quad_t lane_exp [quad_rate][$];
    logic [31:0]  rng_state = 32'd52022;

    raster_top u_raster_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic raster_block_t random_block();
        raster_block_t blk;
        blk       = '0;
        blk.x_loc = raster_dim_t'((next_random() % 64) * 4);
        blk.y_loc = raster_dim_t'((next_random() % 64) * 4);
        blk.pid   = raster_data_t'(next_random());
        for (int k = 0; k < 3; k++) begin
            blk.edges[k].a        = raster_data_t'(int'(next_random() % 16) - 8);
            blk.edges[k].b        = raster_data_t'(int'(next_random() % 16) - 8);
            blk.edges[k].c        = raster_data_t'(next_random());
            blk.edge_func_val[k]  = raster_data_t'(int'(next_random() % 50) - 10);
        end
        return blk;
    endfunction

    // Reference model, evaluates every pixel straight from the edge rule
    task automatic add_expected(input raster_block_t blk);
        raster_quad_t qd;
        raster_dim_t  px;
        raster_dim_t  py;
        raster_data_t v;
        int           dx;
        int           dy;
        for (int q = 0; q < quad_side * quad_side; q++) begin
            qd       = '0;
            px       = blk.x_loc + raster_dim_t'(2 * (q / quad_side));
            py       = blk.y_loc + raster_dim_t'(2 * (q % quad_side));
            qd.x_loc = px >> 1;
            qd.y_loc = py >> 1;
            qd.pid   = blk.pid;
            for (int p = 0; p < 4; p++) begin
                dx         = 2 * (q / quad_side) + (p % 2);
                dy         = 2 * (q % quad_side) + (p / 2);
                qd.mask[p] = 1'b1;
                for (int k = 0; k < 3; k++) begin
                    v = blk.edge_func_val[k] + raster_data_t'(dx) * blk.edges[k].a
                        + raster_data_t'(dy) * blk.edges[k].b;
                    qd.bcoords[k][p] = v;
                    if (v < 0) begin
                        qd.mask[p] = 1'b0;
                    end
                end
            end
            if (qd.mask != 4'b0000) begin
                lane_exp[q % quad_rate].push_back(qd);
            end
        end
    endtask

    function automatic logic lanes_drained();
        for (int l = 0; l < quad_rate; l++) begin
            if (lane_exp[l].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Starts on the next falling edge, holds the block until taken
    task automatic send_block(input raster_block_t blk);
        int waited;
        waited = 0;
        @(negedge clk);
        block       = blk;
        block_valid = 1'b1;
        while (!block_ready) begin
            waited++;
            if (waited > 500) begin
                fail_now("timeout: block_ready stayed low while sending a block");
            end
            @(negedge clk);
        end
        add_expected(blk);
        @(negedge clk);
        block_valid = 1'b0;
    endtask

    // Called on a falling edge; checks the heads that the next edge removes
    task automatic pop_and_check(input logic do_pop);
        raster_quad_t exp_quad;
        for (int l = 0; l < quad_rate; l++) begin
            if (do_pop && quad_valid[l]) begin
                assert (lane_exp[l].size() > 0)
                else fail_now($sformatf("unexpected quad on lane %0d at %0t", l, $time));
                exp_quad = lane_exp[l].pop_front();
                assert (quads[l].mask != 4'b0000)
                else fail_now($sformatf("mismatch at %0t: quad with empty mask on lane %0d",
                    $time, l));
                assert (quads[l] == exp_quad)
                else fail_now($sformatf(
                    "mismatch at %0t: lane %0d got (%0d,%0d) %b pid %0d, exp (%0d,%0d) %b pid %0d",
                    $time, l, quads[l].x_loc, quads[l].y_loc, quads[l].mask, quads[l].pid,
                    exp_quad.x_loc, exp_quad.y_loc, exp_quad.mask, exp_quad.pid));
            end
        end
        quad_pop = do_pop;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!lanes_drained()) begin
            @(negedge clk);
            pop_and_check(1'b1);
            waited++;
            if (waited > 2000) begin
                fail_now("timeout: expected quads never reached the output");
            end
        end
        @(negedge clk);
        quad_pop = 1'b0;
        assert (quad_empty)
        else fail_now("output still holds quads after every expected quad was popped");
    endtask

    task automatic check_after_reset();
        assert (quad_empty && quad_valid == '0 && block_ready)
        else fail_now($sformatf("mismatch at %0t: wrong output state after reset", $time));
    endtask

    task automatic full_coverage();
        raster_block_t blk;
        blk       = '0;
        blk.x_loc = 16'd40;
        blk.y_loc = 16'd20;
        blk.pid   = 32'd11;
        for (int k = 0; k < 3; k++) begin
            blk.edges[k].a       = 32'sd3;
            blk.edges[k].b       = -32'sd2;
            blk.edges[k].c       = 32'sd1000;
            blk.edge_func_val[k] = 32'sd1000;
        end
        send_block(blk);
        drain();
    endtask

    task automatic partial_coverage();
        raster_block_t blk;
        blk                  = '0;
        blk.x_loc            = 16'd8;
        blk.y_loc            = 16'd4;
        blk.pid              = 32'd22;
        // Edge 0 is x - y, so the lower left quad is outside
        blk.edges[0].a       = 32'sd1;
        blk.edges[0].b       = -32'sd1;
        blk.edge_func_val[1] = 32'sd5;
        blk.edge_func_val[2] = 32'sd5;
        send_block(blk);
        drain();
    endtask

    task automatic outside_edge();
        raster_block_t blk;
        blk                  = '0;
        blk.pid              = 32'd33;
        blk.edge_func_val[0] = -32'sd100;
        blk.edge_func_val[1] = 32'sd100;
        blk.edge_func_val[2] = 32'sd100;
        send_block(blk);
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            assert (quad_empty)
            else fail_now($sformatf("mismatch at %0t: quad produced by an outside block", $time));
        end
    endtask

    task automatic back_pressure();
        int sent;
        sent = 0;
        while (block_ready) begin
            send_block(random_block());
            sent++;
            if (sent > 200) begin
                fail_now("timeout: block_ready never fell without pops");
            end
        end
        drain();
    endtask

    task automatic mixed_traffic();
        int   sent;
        int   cycles;
        logic accepted;
        sent     = 0;
        cycles   = 0;
        accepted = 1'b0;
        while (sent < 40) begin
            @(negedge clk);
            if (accepted) begin
                block_valid = 1'b0;
            end
            if (!block_valid && (next_random() % 2 == 1)) begin
                block       = random_block();
                block_valid = 1'b1;
            end
            pop_and_check(next_random() % 3 != 0);
            accepted = block_valid && block_ready;
            if (accepted) begin
                add_expected(block);
                sent++;
            end
            cycles++;
            if (cycles > 3000) begin
                fail_now("timeout: blocks were not accepted during mixed traffic");
            end
        end
        @(negedge clk);
        block_valid = 1'b0;
        quad_pop    = 1'b0;
        drain();
    endtask

    initial begin
        reset       = 1'b1;
        block_valid = 1'b0;
        block       = '0;
        quad_pop    = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_after_reset();
        full_coverage();
        partial_coverage();
        outside_edge();
        back_pressure();
        mixed_traffic();
        $display("TB PASSED");
        $finish;
    end

endmodule
